//--- logic/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0] resetVector = 32'h0040_0000;
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opJal = 6'h03;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti = 6'h0a;
    localparam logic [5:0] opSltiu = 6'h0b;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opXori = 6'h0e;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // function codes under opSpecial
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnSra = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnJr = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnNor = 6'h27;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAddu, aluSubu, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    // immReg means operand B comes from rt
    typedef enum logic [1:0] {immReg, immSign, immZero, immShamt} immKind_t;

    typedef enum logic [2:0] {brNone, brBeq, brBne, brJ, brJal, brJr} branchKind_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic useRs;
        logic useRt;
        immKind_t immKind;
        logic regWrite;
        logic [regAddrWidth-1:0] destReg;
        logic memRead;
        logic memWrite;
        branchKind_t branchKind;
        logic isLink;
    } decoded_t;

    typedef struct packed {
        logic useRs;
        logic [regAddrWidth-1:0] rs;
        logic useRt;
        logic [regAddrWidth-1:0] rt;
    } srcRegs_t;

    typedef struct packed {
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] storeData;
        aluOp_t aluOp;
        logic regWrite;
        logic [regAddrWidth-1:0] destReg;
        logic memRead;
        logic memWrite;
    } idEx_t;

    typedef struct packed {
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] storeData;
        logic regWrite;
        logic [regAddrWidth-1:0] destReg;
        logic memRead;
        logic memWrite;
    } exMem_t;

    typedef struct packed {
        logic [dataWidth-1:0] result;
        logic regWrite;
        logic [regAddrWidth-1:0] destReg;
    } memWb_t;

    typedef struct packed {
        logic read;
        logic write;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } dmemReq_t;

    typedef struct packed {
        logic regWrite;
        logic [regAddrWidth-1:0] destReg;
    } pendingWrite_t;

endpackage

//--- logic/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  logic [mipsPkg::dataWidth-1:0] inst,
    output mipsPkg::decoded_t             dec
);
    import mipsPkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;

    assign op = inst[31:26];
    assign funct = inst[5:0];
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    always_comb begin
        dec = '0;
        dec.aluOp = aluAddu;
        dec.immKind = immReg;
        dec.branchKind = brNone;
        case (op)
            opSpecial: begin
                dec.useRs = 1'b1;
                dec.useRt = 1'b1;
                dec.regWrite = 1'b1;
                dec.destReg = rd;
                case (funct)
                    fnAddu: dec.aluOp = aluAddu;
                    fnSubu: dec.aluOp = aluSubu;
                    fnAnd: dec.aluOp = aluAnd;
                    fnOr: dec.aluOp = aluOr;
                    fnXor: dec.aluOp = aluXor;
                    fnNor: dec.aluOp = aluNor;
                    fnSlt: dec.aluOp = aluSlt;
                    fnSltu: dec.aluOp = aluSltu;
                    fnSllv: dec.aluOp = aluSll;
                    fnSrlv: dec.aluOp = aluSrl;
                    fnSrav: dec.aluOp = aluSra;
                    fnSll, fnSrl, fnSra: begin
                        // shift by shamt, rs is not read
                        dec.useRs = 1'b0;
                        dec.immKind = immShamt;
                        dec.aluOp = (funct == fnSll) ? aluSll :
                                    (funct == fnSrl) ? aluSrl : aluSra;
                    end
                    fnJr: begin
                        dec.useRt = 1'b0;
                        dec.regWrite = 1'b0;
                        dec.branchKind = brJr;
                    end
                    default: begin
                        dec.useRs = 1'b0;
                        dec.useRt = 1'b0;
                        dec.regWrite = 1'b0;
                    end
                endcase
            end
            opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opLw: begin
                dec.useRs = (op != opLui);
                dec.regWrite = 1'b1;
                dec.destReg = rt;
                dec.memRead = (op == opLw);
                dec.immKind = (op inside {opAndi, opOri, opXori, opLui}) ? immZero : immSign;
                case (op)
                    opSlti: dec.aluOp = aluSlt;
                    opSltiu: dec.aluOp = aluSltu;
                    opAndi: dec.aluOp = aluAnd;
                    opOri: dec.aluOp = aluOr;
                    opXori: dec.aluOp = aluXor;
                    opLui: dec.aluOp = aluLui;
                    default: dec.aluOp = aluAddu;
                endcase
            end
            opSw: begin
                dec.useRs = 1'b1;
                dec.useRt = 1'b1;
                dec.immKind = immSign;
                dec.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                dec.useRs = 1'b1;
                dec.useRt = 1'b1;
                dec.branchKind = (op == opBeq) ? brBeq : brBne;
            end
            opJ: dec.branchKind = brJ;
            opJal: begin
                dec.branchKind = brJal;
                dec.isLink = 1'b1;
                dec.regWrite = 1'b1;
                dec.destReg = linkReg;
            end
            default: ;
        endcase
        // covers the all-zero nop too, its rd is r0
        if (dec.destReg == '0) begin
            dec.regWrite = 1'b0;
        end
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
    input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
    output logic [mipsPkg::dataWidth-1:0]    rsData,
    output logic [mipsPkg::dataWidth-1:0]    rtData,
    input  mipsPkg::memWb_t                  wr
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [1:(2**regAddrWidth)-1];

    // write-first, the WB value is visible in the same cycle
    function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr.regWrite && wr.destReg == addr) begin
            return wr.result;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.regWrite && wr.destReg != '0) begin
            regs[wr.destReg] <= wr.result;
        end
    end

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

    // r0 writes must already be filtered at decode
    assert property (@(posedge clk) disable iff (rst) wr.regWrite |-> wr.destReg != '0);

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::srcRegs_t      idSrc,
    input  mipsPkg::pendingWrite_t exPending,
    input  mipsPkg::pendingWrite_t memPending,
    output logic                   stall
);
    import mipsPkg::*;

    function automatic logic srcHit(
        input logic srcUsed,
        input logic [regAddrWidth-1:0] srcReg,
        input pendingWrite_t pending
    );
        return srcUsed && pending.regWrite && pending.destReg == srcReg;
    endfunction

    // WB needs no check, the register file reads write-first
    always_comb begin
        stall = srcHit(idSrc.useRs, idSrc.rs, exPending)
             || srcHit(idSrc.useRt, idSrc.rt, exPending)
             || srcHit(idSrc.useRs, idSrc.rs, memPending)
             || srcHit(idSrc.useRt, idSrc.rt, memPending);
        assert final (!$isunknown(stall));
    end

endmodule

//--- logic/fetchDecodeStage.sv
`timescale 1ns/1ps

module fetchDecodeStage (
    input  logic                          clk,
    input  logic                          rst,
    output logic [mipsPkg::dataWidth-1:0] imemAddr,
    input  logic [mipsPkg::dataWidth-1:0] imemData,
    input  logic                          stall,
    input  mipsPkg::memWb_t               wbWrite,
    output mipsPkg::srcRegs_t             idSrc,
    output mipsPkg::idEx_t                idEx
);
    import mipsPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] nextPc;
    logic [dataWidth-1:0] ifIdInst;
    logic [dataWidth-1:0] ifIdNpc;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic [dataWidth-1:0] sextImm;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] jumpTarget;
    decoded_t dec;
    idEx_t idNext;

    instDecoder u_decoder (
        .inst(ifIdInst),
        .dec (dec)
    );

    regFile u_regFile (
        .clk   (clk),
        .rst   (rst),
        .rsAddr(ifIdInst[25:21]),
        .rtAddr(ifIdInst[20:16]),
        .rsData(rsData),
        .rtData(rtData),
        .wr    (wbWrite)
    );

    assign imemAddr = pc;
    assign idSrc = '{useRs: dec.useRs, rs: ifIdInst[25:21],
                     useRt: dec.useRt, rt: ifIdInst[20:16]};

    // ifIdNpc is the delay slot address
    assign sextImm = {{16{ifIdInst[15]}}, ifIdInst[15:0]};
    assign branchTarget = ifIdNpc + {sextImm[29:0], 2'b00};
    assign jumpTarget = {ifIdNpc[31:28], ifIdInst[25:0], 2'b00};

    always_comb begin
        case (dec.branchKind)
            brBeq: nextPc = (rsData == rtData) ? branchTarget : pc + 32'd4;
            brBne: nextPc = (rsData != rtData) ? branchTarget : pc + 32'd4;
            brJ, brJal: nextPc = jumpTarget;
            brJr: nextPc = rsData;
            default: nextPc = pc + 32'd4;
        endcase
    end

    always_comb begin
        idNext.aluOp = dec.aluOp;
        idNext.regWrite = dec.regWrite;
        idNext.destReg = dec.destReg;
        idNext.memRead = dec.memRead;
        idNext.memWrite = dec.memWrite;
        idNext.storeData = rtData;
        case (dec.immKind)
            immSign: idNext.opB = sextImm;
            immZero: idNext.opB = {16'b0, ifIdInst[15:0]};
            default: idNext.opB = rtData;
        endcase
        if (dec.isLink) begin
            // jal return address, added to zero in EX
            idNext.opA = ifIdNpc + 32'd4;
            idNext.opB = '0;
        end else if (dec.immKind == immShamt) begin
            idNext.opA = {27'b0, ifIdInst[10:6]};
        end else begin
            idNext.opA = rsData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= resetVector;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifIdInst <= '0;
            ifIdNpc <= resetVector;
        end else if (!stall) begin
            ifIdInst <= imemData;
            ifIdNpc <= pc + 32'd4;
        end
    end

    // bubble into EX while decode waits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idEx <= '0;
        end else if (stall) begin
            idEx <= '0;
        end else begin
            idEx <= idNext;
        end
    end

    assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc));

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                   clk,
    input  logic                   rst,
    input  mipsPkg::idEx_t         idEx,
    output mipsPkg::exMem_t        exMem,
    output mipsPkg::pendingWrite_t exPending
);
    import mipsPkg::*;

    logic [dataWidth-1:0] aluResult;
    logic [4:0] shamt;

    assign shamt = idEx.opA[4:0];
    assign exPending = '{regWrite: idEx.regWrite, destReg: idEx.destReg};

    always_comb begin
        aluResult = '0;
        case (idEx.aluOp)
            aluAddu: aluResult = idEx.opA + idEx.opB;
            aluSubu: aluResult = idEx.opA - idEx.opB;
            aluAnd: aluResult = idEx.opA & idEx.opB;
            aluOr: aluResult = idEx.opA | idEx.opB;
            aluXor: aluResult = idEx.opA ^ idEx.opB;
            aluNor: aluResult = ~(idEx.opA | idEx.opB);
            aluSlt: aluResult[0] = $signed(idEx.opA) < $signed(idEx.opB);
            aluSltu: aluResult[0] = idEx.opA < idEx.opB;
            // shifts act on opB, amount from opA
            aluSll: aluResult = idEx.opB << shamt;
            aluSrl: aluResult = idEx.opB >> shamt;
            aluSra: aluResult = $signed(idEx.opB) >>> shamt;
            aluLui: aluResult = {idEx.opB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.result <= aluResult;
            exMem.storeData <= idEx.storeData;
            exMem.regWrite <= idEx.regWrite;
            exMem.destReg <= idEx.destReg;
            exMem.memRead <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
        end
    end

endmodule

//--- logic/memWriteback.sv
`timescale 1ns/1ps

module memWriteback (
    input  logic                          clk,
    input  logic                          rst,
    input  mipsPkg::exMem_t               exMem,
    output mipsPkg::dmemReq_t             dmemReq,
    input  logic [mipsPkg::dataWidth-1:0] dmemRdata,
    output mipsPkg::pendingWrite_t        memPending,
    output mipsPkg::memWb_t               wbWrite
);
    import mipsPkg::*;

    // one request per load or store, address is the ALU sum
    assign dmemReq = '{read: exMem.memRead, write: exMem.memWrite,
                       addr: exMem.result, wdata: exMem.storeData};
    assign memPending = '{regWrite: exMem.regWrite, destReg: exMem.destReg};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbWrite <= '0;
        end else begin
            wbWrite.result <= exMem.memRead ? dmemRdata : exMem.result;
            wbWrite.regWrite <= exMem.regWrite;
            wbWrite.destReg <= exMem.destReg;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(dmemReq.read && dmemReq.write));

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic                          clk,
    input  logic                          rst,
    output logic [mipsPkg::dataWidth-1:0] imemAddr,
    input  logic [mipsPkg::dataWidth-1:0] imemData,
    output mipsPkg::dmemReq_t             dmemReq,
    input  logic [mipsPkg::dataWidth-1:0] dmemRdata
);
    import mipsPkg::*;

    idEx_t idEx;
    exMem_t exMem;
    memWb_t wbWrite;
    srcRegs_t idSrc;
    pendingWrite_t exPending;
    pendingWrite_t memPending;
    logic stall;

    fetchDecodeStage u_fetchDecode (
        .clk     (clk),
        .rst     (rst),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .stall   (stall),
        .wbWrite (wbWrite),
        .idSrc   (idSrc),
        .idEx    (idEx)
    );

    executeStage u_execute (
        .clk      (clk),
        .rst      (rst),
        .idEx     (idEx),
        .exMem    (exMem),
        .exPending(exPending)
    );

    memWriteback u_memWb (
        .clk       (clk),
        .rst       (rst),
        .exMem     (exMem),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .memPending(memPending),
        .wbWrite   (wbWrite)
    );

    hazardUnit u_hazard (
        .idSrc     (idSrc),
        .exPending (exPending),
        .memPending(memPending),
        .stall     (stall)
    );

endmodule

//--- sim/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} memRec_t;

memRec_t expStores[$];
logic [31:0] expLoads[$];
int modelStoreTotal;

// data memory contents before any store
function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic logic [31:0] fetchWord(input logic [31:0] addr);
    int unsigned idx;
    idx = (addr - resetVector) >> 2;
    if (addr < resetVector || idx >= prog.size()) begin
        return '0;
    end
    return prog[idx];
endfunction

// in-order run with one delay slot, stops when the self-loop is reached
task automatic runModel(input logic [31:0] stopAddr);
    logic [31:0] r [32];
    logic [31:0] modelMem [int unsigned];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] target;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [4:0] dst;
    logic [4:0] sa;
    bit wr;
    int steps;
    foreach (r[i]) begin
        r[i] = '0;
    end
    pc = resetVector;
    npc = resetVector + 32'd4;
    steps = 0;
    while (pc != stopAddr && steps < 20000) begin
        inst = fetchWord(pc);
        a = r[inst[25:21]];
        b = r[inst[20:16]];
        sa = inst[10:6];
        imm = {{16{inst[15]}}, inst[15:0]};
        target = npc + 32'd4;
        dst = inst[20:16];
        wr = 1'b1;
        res = '0;
        case (inst[31:26])
            6'h00: begin
                dst = inst[15:11];
                case (inst[5:0])
                    6'h00: res = b << sa;
                    6'h02: res = b >> sa;
                    6'h03: res = $signed(b) >>> sa;
                    6'h04: res = b << a[4:0];
                    6'h06: res = b >> a[4:0];
                    6'h07: res = $signed(b) >>> a[4:0];
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                    6'h08: begin
                        // jr
                        wr = 1'b0;
                        target = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            6'h02: begin
                wr = 1'b0;
                target = {npc[31:28], inst[25:0], 2'b00};
            end
            6'h03: begin
                dst = 5'd31;
                res = pc + 32'd8;
                target = {npc[31:28], inst[25:0], 2'b00};
            end
            6'h04, 6'h05: begin
                wr = 1'b0;
                if ((a == b) == (inst[31:26] == 6'h04)) begin
                    target = npc + {imm[29:0], 2'b00};
                end
            end
            6'h09: res = a + imm;
            6'h0a: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            6'h0b: res = (a < imm) ? 32'd1 : 32'd0;
            6'h0c: res = a & {16'h0000, inst[15:0]};
            6'h0d: res = a | {16'h0000, inst[15:0]};
            6'h0e: res = a ^ {16'h0000, inst[15:0]};
            6'h0f: res = {inst[15:0], 16'h0000};
            6'h23: begin
                ea = a + imm;
                expLoads.push_back(ea);
                res = modelMem.exists(ea >> 2) ? modelMem[ea >> 2] : fillWord(ea);
            end
            6'h2b: begin
                wr = 1'b0;
                ea = a + imm;
                expStores.push_back(memRec_t'{addr: ea, data: b});
                modelMem[ea >> 2] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            r[dst] = res;
        end
        pc = npc;
        npc = target;
        steps++;
    end
    modelStoreTotal = expStores.size();
endtask

`endif

//--- sim/mipsCore_tb.sv
`timescale 1ns/1ps

module mipsCore_tb;
    import mipsPkg::*;

    localparam int bodyItems = 120;
    localparam logic [31:0] dataBase = 32'h1001_0000;
    localparam int loopTimeout = 6000;
    localparam int drainTimeout = 200;

    typedef struct packed {
        int idx;
        int item;
        logic [1:0] kind;
    } fixup_t;

    logic clk;
    logic rst;
    logic [dataWidth-1:0] imemAddr;
    logic [dataWidth-1:0] imemData;
    dmemReq_t dmemReq;
    logic [dataWidth-1:0] dmemRdata;

    logic [31:0] prog[$];
    int itemStart[$];
    fixup_t fixups[$];
    logic [31:0] loopAddr;
    logic [31:0] dataMem [int unsigned];
    bit memFetched;
    bit loopSeen;
    int storeCount;
    int mismatches;
    int otherErrors;

    `include "isaModel.svh"

    mipsCore u_dut (
        .clk      (clk),
        .rst      (rst),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .dmemReq  (dmemReq),
        .dmemRdata(dmemRdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic int unsigned pick(input int unsigned n);
        return $urandom % n;
    endfunction

    // small pools so that neighbours often depend on each other
    function automatic logic [4:0] srcReg();
        return 5'(pick(16));
    endfunction

    function automatic logic [4:0] dstReg();
        return 5'(1 + pick(12));
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {opSpecial, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emitPlain();
        logic [5:0] rFns [11];
        logic [5:0] iOps [7];
        logic [5:0] shFn;
        rFns = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
                 fnSllv, fnSrlv, fnSrav};
        iOps = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
        shFn = (pick(3) == 0) ? fnSll : ((pick(2) == 0) ? fnSrl : fnSra);
        case (pick(6))
            0, 1: prog.push_back(rType(srcReg(), srcReg(), dstReg(), 5'd0, rFns[pick(11)]));
            2: prog.push_back(rType(5'd0, srcReg(), dstReg(), 5'(pick(32)), shFn));
            3: prog.push_back(iType(iOps[pick(7)], srcReg(), dstReg(), 16'($urandom)));
            4: prog.push_back(iType(opLw, 5'd28, dstReg(), 16'(4 * pick(64))));
            default: prog.push_back(iType(opSw, 5'd28, 5'(pick(32)), 16'(4 * pick(64))));
        endcase
    endtask

    // kind 0 branch offset, 1 jump index, 2 upper half, 3 lower half
    task automatic addFix(input int kind, input int item);
        fixups.push_back(fixup_t'{idx: prog.size(), item: item, kind: 2'(kind)});
    endtask

    task automatic emitControl(input int item);
        int tgt;
        logic [4:0] rs;
        logic [4:0] rt;
        tgt = item + 1 + int'(pick(4));
        if (tgt > bodyItems) begin
            tgt = bodyItems;
        end
        rs = srcReg();
        rt = (pick(3) == 0) ? rs : srcReg();
        case (pick(4))
            0: begin
                addFix(0, tgt);
                prog.push_back(iType((pick(2) == 0) ? opBeq : opBne, rs, rt, 16'h0000));
            end
            1: begin
                addFix(1, tgt);
                prog.push_back({opJ, 26'h0});
            end
            2: begin
                addFix(1, tgt);
                prog.push_back({opJal, 26'h0});
            end
            default: begin
                // r29 only ever holds jr targets
                addFix(2, tgt);
                prog.push_back(iType(opLui, 5'd0, 5'd29, 16'h0000));
                addFix(3, tgt);
                prog.push_back(iType(opOri, 5'd29, 5'd29, 16'h0000));
                prog.push_back(rType(5'd29, 5'd0, 5'd0, 5'd0, fnJr));
            end
        endcase
        emitPlain();
    endtask

    task automatic resolveFixups();
        logic [31:0] tgtAddr;
        logic [31:0] at;
        logic [31:0] off;
        logic [31:0] w;
        foreach (fixups[i]) begin
            tgtAddr = resetVector + 32'(4 * itemStart[fixups[i].item]);
            at = resetVector + 32'(4 * fixups[i].idx);
            off = (tgtAddr - (at + 32'd4)) >> 2;
            w = prog[fixups[i].idx];
            case (fixups[i].kind)
                2'd0: w[15:0] = off[15:0];
                2'd1: w[25:0] = tgtAddr[27:2];
                2'd2: w[15:0] = tgtAddr[31:16];
                default: w[15:0] = tgtAddr[15:0];
            endcase
            prog[fixups[i].idx] = w;
        end
    endtask

    task automatic genProgram();
        for (int r = 1; r < 32; r++) begin
            if (r == 28) begin
                prog.push_back(iType(opLui, 5'd0, 5'd28, dataBase[31:16]));
            end else if (r != 29) begin
                prog.push_back(iType(opLui, 5'd0, 5'(r), 16'($urandom)));
                prog.push_back(iType(opOri, 5'(r), 5'(r), 16'($urandom)));
            end
        end
        for (int item = 0; item < bodyItems; item++) begin
            itemStart.push_back(prog.size());
            if (pick(100) < 18) begin
                emitControl(item);
            end else begin
                emitPlain();
            end
        end
        // register dump, then the self-loop
        itemStart.push_back(prog.size());
        for (int r = 1; r < 32; r++) begin
            prog.push_back(iType(opSw, 5'd28, 5'(r), 16'(4 * (r - 1))));
        end
        loopAddr = resetVector + 32'(4 * prog.size());
        prog.push_back({opJ, loopAddr[27:2]});
        prog.push_back(32'h0);
        resolveFixups();
    endtask

    function automatic logic [31:0] readWord(input logic [31:0] addr);
        if (dataMem.exists(addr >> 2)) begin
            return dataMem[addr >> 2];
        end
        return fillWord(addr);
    endfunction

    task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkStore(input dmemReq_t req, input memRec_t exp);
        checkWord("dmemReq.addr (store)", req.addr, exp.addr);
        checkWord("dmemReq.wdata", req.wdata, exp.data);
    endtask

    task automatic checkLoad(input dmemReq_t req, input logic [dataWidth-1:0] expAddr);
        checkWord("dmemReq.addr (load)", req.addr, expAddr);
    endtask

    // memories answer on the falling edge
    always @(negedge clk) begin
        if ((dmemReq.read || dmemReq.write) && !memFetched) begin
            otherErrors++;
            $display("request strobe high before any load or store was fetched");
        end
        if (dmemReq.write) begin
            storeCount++;
            if (expStores.size() == 0) begin
                otherErrors++;
                $display("store to 0x%08h has no store left in the model", dmemReq.addr);
            end else begin
                checkStore(dmemReq, expStores.pop_front());
            end
            dataMem[dmemReq.addr >> 2] = dmemReq.wdata;
        end
        dmemRdata = '0;
        if (dmemReq.read) begin
            if (expLoads.size() == 0) begin
                otherErrors++;
                $display("load from 0x%08h has no load left in the model", dmemReq.addr);
            end else begin
                checkLoad(dmemReq, expLoads.pop_front());
            end
            dmemRdata = readWord(dmemReq.addr);
        end
        imemData = fetchWord(imemAddr);
        if (imemData[31:26] == opLw || imemData[31:26] == opSw) begin
            memFetched = 1'b1;
        end
        if (imemAddr == loopAddr) begin
            loopSeen = 1'b1;
        end
    end

    task automatic waitForLoop(output bit ok);
        int cycles;
        cycles = 0;
        while (!loopSeen && cycles < loopTimeout) begin
            @(posedge clk);
            cycles++;
        end
        ok = loopSeen;
        if (!ok) begin
            otherErrors++;
            $display("timeout: the self-loop address was never fetched");
        end
    endtask

    task automatic waitForStores(output bit ok);
        int cycles;
        cycles = 0;
        while (expStores.size() != 0 && cycles < drainTimeout) begin
            @(posedge clk);
            cycles++;
        end
        ok = (expStores.size() == 0);
        if (!ok) begin
            otherErrors++;
            $display("timeout: %0d model stores never appeared", expStores.size());
        end
    endtask

    initial begin
        bit ok;
        rst = 1'b1;
        imemData = '0;
        dmemRdata = '0;
        memFetched = 1'b0;
        loopSeen = 1'b0;
        storeCount = 0;
        mismatches = 0;
        otherErrors = 0;
        void'($urandom(32'hb06d));
        genProgram();
        runModel(loopAddr);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkWord("imemAddr", imemAddr, resetVector);
        waitForLoop(ok);
        if (ok) begin
            waitForStores(ok);
        end
        if (ok) begin
            checkWord("store count", 32'(storeCount), 32'(modelStoreTotal));
            if (expLoads.size() != 0) begin
                otherErrors++;
                $display("%0d model loads were never issued", expLoads.size());
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+sim
logic/mipsPkg.sv
logic/instDecoder.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/fetchDecodeStage.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/mipsCore.sv
sim/mipsCore_tb.sv

//--- Bender.yml
package:
  name: mipsCore

sources:
  - logic/mipsPkg.sv
  - logic/instDecoder.sv
  - logic/regFile.sv
  - logic/hazardUnit.sv
  - logic/fetchDecodeStage.sv
  - logic/executeStage.sv
  - logic/memWriteback.sv
  - logic/mipsCore.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/mipsCore_tb.sv
